/* project.f */
+incdir+src
src/lsu_pkg.sv
src/lsu_pipe_stage.sv
src/lsu_store_buffer.sv
src/lsu_fwd_merge.sv
src/lsu_axi_write.sv
src/lsu_bus_top.sv
testbench/lsu_bus_properties.sv
testbench/lsu_bus_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the lsu bus testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f project.f \
  --top-module lsu_bus_tb -Mdir obj_dir -o lsu_bus_sim

./obj_dir/lsu_bus_sim | tee sim.log

if grep -q "Regression passed" sim.log; then
  echo "simulation ok"
else
  echo "simulation reported errors, see sim.log"
  exit 1
fi

/* testbench/lsu_bus_tb.sv */
`timescale 1ns/10ps

`include "lsu_defs.svh"

module lsu_bus_tb;
  import lsu_pkg::*;

  localparam int          NUM_OPS    = 300;
  localparam int          MAX_CYCLES = 20 * NUM_OPS + 200;
  localparam logic [31:0] BASE       = 32'h0000_4000;  // 64 byte test window

  logic                     clk = 1'b0;
  logic                     rst_n;
  logic                     m_valid;
  logic                     m_ready;
  logic                     m_load;
  logic                     m_store;
  access_size_e             m_size;
  logic [31:0]              m_addr;
  word_t                    m_store_data;
  logic                     flush_r;
  logic                     ld_valid;
  logic                     ld_hit;
  word_t                    ld_data;
  logic                     awvalid;
  logic                     awready;
  logic [`LSU_AXI_ID_W-1:0] awid;
  logic [31:0]              awaddr;
  logic [2:0]               awsize;
  logic [1:0]               awburst;
  logic                     wvalid;
  logic                     wready;
  dword_t                   wdata;
  strb_t                    wstrb;
  logic                     wlast;
  logic                     bvalid;
  logic                     bready;
  logic [`LSU_AXI_ID_W-1:0] bid;
  logic [1:0]               bresp;

  logic [31:0]              lfsr = 32'hb497b994;
  logic [7:0]               ref_mem [72];   // window plus the spill of a crossing word
  logic [65:0]              inflight [$];   // {word addr, be, data} in commit order
  logic [`LSU_AXI_ID_W-1:0] resp_ids [$];
  logic [`LSU_AXI_ID_W-1:0] aw_id;
  logic                     aw_seen = 1'b0;
  logic                     w_seen = 1'b0;
  logic                     pop_now = 1'b0;
  int                       cycles = 0;
  int                       committed = 0;
  int                       retired = 0;

  lsu_bus_top dut0 (.*);

  always #4 clk = ~clk;

  // ******************************
  // helpers
  // ******************************
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v    = {v[30:0], lfsr[0]};
      lfsr = {1'b0, lfsr[31:1]} ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
    end
    return v;
  endfunction

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("Regression failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] want);
    assert (got === want)
      else report_failure($sformatf("Mismatch at %0d ns: %s got %0h expected %0h",
                                    $time, name, got, want));
  endtask

  // byte still held by the r stage or the store buffer
  function automatic logic in_flight(input logic [31:0] a);
    foreach (inflight[k]) begin
      if (inflight[k][65:36] == a[31:2] && inflight[k][32 + a[1:0]]) return 1'b1;
    end
    return 1'b0;
  endfunction

  task automatic commit_store(input logic [31:0] addr, input logic [1:0] size,
                              input logic [31:0] data);
    logic [7:0]  be8;
    logic [63:0] d8;
    int          pos;
    be8 = '0;
    d8  = '0;
    for (int i = 0; i < (1 << size); i++) begin
      pos                = int'(addr[1:0]) + i;
      be8[pos]           = 1'b1;
      d8[8*pos +: 8]     = data[8*i +: 8];
      ref_mem[addr - BASE + i] = data[8*i +: 8];
    end
    inflight.push_back({addr[31:2], be8[3:0], d8[31:0]});
    committed++;
    if (be8[7:4] != 4'h0) begin  // crossing store, hi word goes second
      inflight.push_back({addr[31:2] + 30'd1, be8[7:4], d8[63:32]});
      committed++;
    end
  endtask

  task automatic predict_load(input logic [31:0] addr, input logic [1:0] size,
                              output logic hit, output logic [31:0] data);
    logic [31:0] a;
    hit  = 1'b1;
    data = '0;
    for (int i = 0; i < (1 << size); i++) begin
      a              = addr + i;
      hit            = hit & in_flight(a);
      data[8*i +: 8] = ref_mem[a - BASE];
    end
  endtask

  // ******************************
  // AXI slave
  // ******************************
  task automatic serve_axi();
    logic [65:0] head;
    logic [63:0] lane_data;
    logic [7:0]  lane_strb;
    logic [63:0] strb_mask;
    check_value("bready", bready, 1'b1);
    bvalid = (resp_ids.size() != 0);
    bid    = '0;
    if (bvalid) bid = resp_ids.pop_front();
    awready = ((cycles % 128) >= 40) && (rand_bits(2) != 0);  // long aw stall each period
    wready  = (rand_bits(2) != 0);
    pop_now = 1'b0;
    head    = '0;
    if ((awvalid && awready) || (wvalid && wready)) begin
      assert (inflight.size() != 0)
        else report_failure("AXI write issued while no store was pending");
      head      = inflight[0];
      lane_data = head[36] ? {head[31:0], 32'h0} : {32'h0, head[31:0]};
      lane_strb = head[36] ? {head[35:32], 4'h0} : {4'h0, head[35:32]};
      for (int b = 0; b < 8; b++) strb_mask[8*b +: 8] = {8{wstrb[b]}};
      if (awvalid && awready) begin
        check_value("awaddr", awaddr, {head[65:36], 2'b00});
        check_value("awsize", awsize, 3'b010);
        check_value("awburst", awburst, 2'b01);
        check_value("awid", awid, retired % `LSU_SB_DEPTH);  // slot of the head entry
        aw_id   = awid;
        aw_seen = 1'b1;
      end
      if (wvalid && wready) begin
        check_value("wstrb", wstrb, lane_strb);
        check_value("wdata", wdata & strb_mask, lane_data);
        w_seen = 1'b1;
      end
      pop_now = aw_seen && w_seen;
    end
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES)
      report_failure($sformatf("timeout after %0d cycles with %0d of %0d writes retired",
                               cycles, retired, committed));
  end

  // ******************************
  // stimulus and load checks
  // ******************************
  initial begin
    logic        op_held;
    logic        op_load;
    logic        op_flush;
    logic [31:0] op_addr;
    logic [1:0]  op_size;
    logic [31:0] op_data;
    logic [1:0]  kind;
    logic        r_pend;   // store accepted at the last edge
    logic        ld_pend;  // load accepted at the last edge
    logic        exp_hit;
    logic [31:0] exp_data;
    int          n;
    rst_n        = 1'b0;
    m_valid      = 1'b0;
    m_load       = 1'b0;
    m_store      = 1'b0;
    m_size       = size_byte;
    m_addr       = BASE;
    m_store_data = '0;
    flush_r      = 1'b0;
    awready      = 1'b0;
    wready       = 1'b0;
    bvalid       = 1'b0;
    bid          = '0;
    bresp        = 2'b00;
    op_held      = 1'b0;
    op_load      = 1'b0;
    op_flush     = 1'b0;
    op_addr      = BASE;
    op_size      = 2'd0;
    op_data      = '0;
    r_pend       = 1'b0;
    ld_pend      = 1'b0;
    exp_hit      = 1'b0;
    exp_data     = '0;
    n            = 0;
    repeat (3) @(negedge clk);
    rst_n = 1'b1;
    while (n < NUM_OPS || op_held || r_pend || ld_pend || inflight.size() != 0) begin
      @(negedge clk);
      check_value("ld_valid", ld_valid, ld_pend);
      if (ld_pend) begin
        check_value("ld_hit", ld_hit, exp_hit);
        if (exp_hit) check_value("ld_data", ld_data, exp_data);
      end
      // buffer holds every committed entry not yet retired
      check_value("m_ready", m_ready, (`LSU_SB_DEPTH - inflight.size()) >= 4);
      ld_pend = 1'b0;
      flush_r = r_pend && op_flush;  // store sits in r during this cycle
      if (r_pend && !op_flush) commit_store(op_addr, op_size, op_data);
      r_pend = 1'b0;
      serve_axi();
      m_valid = 1'b0;
      m_load  = 1'b0;
      m_store = 1'b0;
      if (!op_held && n < NUM_OPS && rand_bits(3) != 0) begin
        kind     = 2'(rand_bits(2));
        op_held  = 1'b1;
        op_load  = kind[1];
        op_flush = (rand_bits(3) == 0);
        op_data  = rand_bits(32);
        if (kind != 2'd2) begin  // kind 2 loads back the last address
          op_addr = BASE + rand_bits(6);
          op_size = 2'(rand_bits(2));
          if (op_size == 2'd3) op_size = 2'd2;
        end
      end
      if (op_held) begin
        m_valid      = 1'b1;
        m_load       = op_load;
        m_store      = !op_load;
        m_size       = access_size_e'(op_size);
        m_addr       = op_addr;
        m_store_data = op_data;
        if (m_ready) begin  // taken at the coming edge
          op_held = 1'b0;
          n++;
          r_pend  = !op_load;
          ld_pend = op_load;
          if (op_load) predict_load(op_addr, op_size, exp_hit, exp_data);
        end
      end
      if (pop_now) begin
        inflight.delete(0);
        resp_ids.push_back(aw_id);
        retired++;
        aw_seen = 1'b0;
        w_seen  = 1'b0;
      end
    end
    repeat (2) @(negedge clk);  // long enough for a stray entry to raise awvalid
    if (!awvalid && !wvalid) begin
      $display("Regression passed");
      $finish;
    end else begin
      $display("write channel active after the last store retired");
      $display("Regression failed");
      $fatal(1);
    end
  end

endmodule

/* testbench/lsu_bus_properties.sv */
`timescale 1ns/10ps

`include "lsu_defs.svh"

module lsu_bus_properties (
  input logic                     clk,
  input logic                     rst_n,
  input logic                     m_ready,
  input logic                     ld_valid,
  input logic                     head_valid,
  input logic                     awvalid,
  input logic                     awready,
  input logic [`LSU_AXI_ID_W-1:0] awid,
  input logic [31:0]              awaddr,
  input logic [2:0]               awsize,
  input logic                     wvalid,
  input logic                     wready,
  input logic [63:0]              wdata,
  input logic [7:0]               wstrb,
  input logic                     wlast
);

  // ******************************
  // reset and channel rules
  // ******************************
  reset_idle: assert property (@(posedge clk)
    $rose(rst_n) |-> m_ready && !ld_valid && !awvalid && !wvalid && !head_valid)
    else $error("outputs not idle when reset is released");

  aw_hold: assert property (@(posedge clk) disable iff (!rst_n)
    awvalid && !awready |=> awvalid && $stable(awaddr) && $stable(awid) && $stable(awsize))
    else $error("aw channel changed before awready");

  w_hold: assert property (@(posedge clk) disable iff (!rst_n)
    wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wstrb))
    else $error("w channel changed before wready");

  // issue needs a cycle of head before awvalid, awid is the head slot
  aw_after_head: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(awvalid) |-> $past(head_valid) && $stable(awid))
    else $error("awvalid rose without a buffered entry");

  single_beat: assert property (@(posedge clk) disable iff (!rst_n)
    wvalid |-> wlast && (wstrb != 8'h00))
    else $error("w beat is not a single strobed beat");

endmodule

bind lsu_bus_top lsu_bus_properties props0 (
  .clk        (clk),
  .rst_n      (rst_n),
  .m_ready    (m_ready),
  .ld_valid   (ld_valid),
  .head_valid (head_valid),
  .awvalid    (awvalid),
  .awready    (awready),
  .awid       (awid),
  .awaddr     (awaddr),
  .awsize     (awsize),
  .wvalid     (wvalid),
  .wready     (wready),
  .wdata      (wdata),
  .wstrb      (wstrb),
  .wlast      (wlast)
);

/* src/lsu_bus_top.sv */
`timescale 1ns/10ps

`include "lsu_defs.svh"

module lsu_bus_top (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       m_valid,
  output logic                       m_ready,
  input  logic                       m_load,
  input  logic                       m_store,
  input  lsu_pkg::access_size_e      m_size,
  input  logic [31:0]                m_addr,
  input  lsu_pkg::word_t             m_store_data,
  input  logic                       flush_r,
  output logic                       ld_valid,
  output logic                       ld_hit,
  output lsu_pkg::word_t             ld_data,
  output logic                       awvalid,
  input  logic                       awready,
  output logic [`LSU_AXI_ID_W-1:0]   awid,
  output logic [31:0]                awaddr,
  output logic [2:0]                 awsize,
  output logic [1:0]                 awburst,
  output logic                       wvalid,
  input  logic                       wready,
  output lsu_pkg::dword_t            wdata,
  output lsu_pkg::strb_t             wstrb,
  output logic                       wlast,
  input  logic                       bvalid,
  output logic                       bready,
  input  logic [`LSU_AXI_ID_W-1:0]   bid,
  input  logic [1:0]                 bresp
);
  import lsu_pkg::*;

  word_addr_t              m_lo_addr, m_hi_addr;
  byte_en_t                m_lo_be, m_hi_be;
  logic                    m_load_go;
  word_addr_t              r_lo_addr, r_hi_addr;
  byte_en_t                r_lo_be, r_hi_be;
  word_t                   r_lo_data, r_hi_data;
  logic                    r_fwd_valid;
  logic                    enq_valid, enq_dual;
  byte_en_t                buf_hit_lo, buf_hit_hi;
  word_t                   buf_data_lo, buf_data_hi;
  logic [`LSU_SB_PTR_W:0]  sb_free;
  logic                    head_valid, head_pop;
  word_addr_t              head_addr;
  byte_en_t                head_be;
  word_t                   head_data;
  sb_ptr_t                 head_ptr;

  // room for a dual store in r plus a dual store in m
  assign m_ready = (sb_free >= (`LSU_SB_PTR_W+1)'(4));

  lsu_pipe_stage u_pipe (.*);

  lsu_store_buffer u_sbuf (.*);

  lsu_fwd_merge u_fwd (
    .m_addr_off (m_addr[1:0]),
    .*
  );

  lsu_axi_write u_axi_wr (.*);

endmodule

/* src/lsu_axi_write.sv */
`timescale 1ns/10ps

`include "lsu_defs.svh"

module lsu_axi_write (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       head_valid,
  input  lsu_pkg::word_addr_t        head_addr,
  input  lsu_pkg::byte_en_t          head_be,
  input  lsu_pkg::word_t             head_data,
  input  lsu_pkg::sb_ptr_t           head_ptr,
  output logic                       head_pop,
  output logic                       awvalid,
  input  logic                       awready,
  output logic [`LSU_AXI_ID_W-1:0]   awid,
  output logic [31:0]                awaddr,
  output logic [2:0]                 awsize,
  output logic [1:0]                 awburst,
  output logic                       wvalid,
  input  logic                       wready,
  output lsu_pkg::dword_t            wdata,
  output lsu_pkg::strb_t             wstrb,
  output logic                       wlast,
  input  logic                       bvalid,
  output logic                       bready,
  input  logic [`LSU_AXI_ID_W-1:0]   bid,
  input  logic [1:0]                 bresp
);
  import lsu_pkg::*;

  axi_wr_state_e            state;
  axi_wr_state_e            state_nxt;
  logic [`LSU_SB_DEPTH-1:0] id_busy;  // write issued, response not back yet

  // ******************************
  // channel sequencing
  // ******************************
  always_comb begin
    state_nxt = state;
    head_pop  = 1'b0;
    unique case (state)
      wr_idle:    if (head_valid && !id_busy[head_ptr]) state_nxt = wr_both;
      wr_both: begin
        if (awready && wready) begin
          head_pop  = 1'b1;
          state_nxt = wr_idle;
        end else if (awready) begin
          state_nxt = wr_wait_w;
        end else if (wready) begin
          state_nxt = wr_wait_aw;
        end
      end
      wr_wait_aw: if (awready) begin
        head_pop  = 1'b1;
        state_nxt = wr_idle;
      end
      wr_wait_w:  if (wready) begin
        head_pop  = 1'b1;
        state_nxt = wr_idle;
      end
      default:    state_nxt = wr_idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state   <= wr_idle;
      id_busy <= '0;
    end else begin
      state <= state_nxt;
      if (bvalid)            id_busy[bid]  <= 1'b0;
      if (awvalid && awready) id_busy[awid] <= 1'b1;
    end
  end

  // payload comes straight from the head, which holds until the pop
  assign awvalid = (state == wr_both) | (state == wr_wait_aw);
  assign wvalid  = (state == wr_both) | (state == wr_wait_w);
  assign awid    = head_ptr;
  assign awaddr  = {head_addr, 2'b00};
  assign awsize  = `LSU_AXI_SIZE_WORD;
  assign awburst = `LSU_AXI_BURST_INCR;
  assign wdata   = head_addr[0] ? {head_data, 32'h0} : {32'h0, head_data};  // lane by addr[2]
  assign wstrb   = head_addr[0] ? {head_be, 4'h0} : {4'h0, head_be};
  assign wlast   = 1'b1;
  assign bready  = 1'b1;  // every response is taken, bresp ignored

endmodule

/* src/lsu_fwd_merge.sv */
`timescale 1ns/10ps

module lsu_fwd_merge (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  m_load_go,
  input  lsu_pkg::byte_en_t     m_lo_be,
  input  lsu_pkg::byte_en_t     m_hi_be,
  input  logic [1:0]            m_addr_off,
  input  logic                  r_fwd_valid,
  input  lsu_pkg::word_addr_t   r_lo_addr,
  input  lsu_pkg::word_addr_t   r_hi_addr,
  input  lsu_pkg::byte_en_t     r_lo_be,
  input  lsu_pkg::byte_en_t     r_hi_be,
  input  lsu_pkg::word_t        r_lo_data,
  input  lsu_pkg::word_t        r_hi_data,
  input  lsu_pkg::word_addr_t   m_lo_addr,
  input  lsu_pkg::word_addr_t   m_hi_addr,
  input  lsu_pkg::byte_en_t     buf_hit_lo,
  input  lsu_pkg::byte_en_t     buf_hit_hi,
  input  lsu_pkg::word_t        buf_data_lo,
  input  lsu_pkg::word_t        buf_data_hi,
  output logic                  ld_valid,
  output logic                  ld_hit,
  output lsu_pkg::word_t        ld_data
);
  import lsu_pkg::*;

  // first half of the name is the r word, second the m word
  logic      rhit_lo_lo;
  logic      rhit_lo_hi;
  logic      rhit_hi_lo;
  logic      rhit_hi_hi;
  byte_en_t  byte_hit_lo;
  byte_en_t  byte_hit_hi;
  word_t     fwd_lo;
  word_t     fwd_hi;
  dword_t    fwd_dw;
  logic      full_hit;

  assign rhit_lo_lo = r_fwd_valid & (r_lo_addr == m_lo_addr);
  assign rhit_lo_hi = r_fwd_valid & (r_lo_addr == m_hi_addr);
  assign rhit_hi_lo = r_fwd_valid & (r_hi_addr == m_lo_addr);
  assign rhit_hi_hi = r_fwd_valid & (r_hi_addr == m_hi_addr);

  // per byte merge, r stage is younger than anything buffered
  always_comb begin
    for (int i = 0; i < 4; i++) begin
      byte_hit_lo[i] = m_lo_be[i] & (buf_hit_lo[i] | (rhit_lo_lo & r_lo_be[i]) |
                                     (rhit_hi_lo & r_hi_be[i]));
      byte_hit_hi[i] = m_hi_be[i] & (buf_hit_hi[i] | (rhit_lo_hi & r_lo_be[i]) |
                                     (rhit_hi_hi & r_hi_be[i]));
      if (!m_lo_be[i])                    fwd_lo[8*i +: 8] = 8'h00;  // zero unused bytes
      else if (rhit_lo_lo && r_lo_be[i])  fwd_lo[8*i +: 8] = r_lo_data[8*i +: 8];
      else if (rhit_hi_lo && r_hi_be[i])  fwd_lo[8*i +: 8] = r_hi_data[8*i +: 8];
      else                                fwd_lo[8*i +: 8] = buf_data_lo[8*i +: 8];
      if (!m_hi_be[i])                    fwd_hi[8*i +: 8] = 8'h00;
      else if (rhit_lo_hi && r_lo_be[i])  fwd_hi[8*i +: 8] = r_lo_data[8*i +: 8];
      else if (rhit_hi_hi && r_hi_be[i])  fwd_hi[8*i +: 8] = r_hi_data[8*i +: 8];
      else                                fwd_hi[8*i +: 8] = buf_data_hi[8*i +: 8];
    end
  end

  // every enabled byte must be found somewhere
  assign full_hit = (byte_hit_lo == m_lo_be) & (byte_hit_hi == m_hi_be);
  assign fwd_dw   = {fwd_hi, fwd_lo} >> {m_addr_off, 3'b000};

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ld_valid <= 1'b0;
      ld_hit   <= 1'b0;
    end else begin
      ld_valid <= m_load_go;
      ld_hit   <= m_load_go & full_hit;
    end
  end

  always_ff @(posedge clk) begin
    if (m_load_go) ld_data <= fwd_dw[31:0];  // aligned, zero extended
  end

endmodule

/* src/lsu_store_buffer.sv */
`timescale 1ns/10ps

`include "lsu_defs.svh"

module lsu_store_buffer (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      enq_valid,
  input  logic                      enq_dual,
  input  lsu_pkg::word_addr_t       r_lo_addr,
  input  lsu_pkg::word_addr_t       r_hi_addr,
  input  lsu_pkg::byte_en_t         r_lo_be,
  input  lsu_pkg::byte_en_t         r_hi_be,
  input  lsu_pkg::word_t            r_lo_data,
  input  lsu_pkg::word_t            r_hi_data,
  input  lsu_pkg::word_addr_t       m_lo_addr,
  input  lsu_pkg::word_addr_t       m_hi_addr,
  output lsu_pkg::byte_en_t         buf_hit_lo,
  output lsu_pkg::byte_en_t         buf_hit_hi,
  output lsu_pkg::word_t            buf_data_lo,
  output lsu_pkg::word_t            buf_data_hi,
  output logic [`LSU_SB_PTR_W:0]    sb_free,
  output logic                      head_valid,
  output lsu_pkg::word_addr_t       head_addr,
  output lsu_pkg::byte_en_t         head_be,
  output lsu_pkg::word_t            head_data,
  output lsu_pkg::sb_ptr_t          head_ptr,
  input  logic                      head_pop
);
  import lsu_pkg::*;

  word_addr_t  sb_addr [`LSU_SB_DEPTH];
  byte_en_t    sb_be   [`LSU_SB_DEPTH];
  word_t       sb_data [`LSU_SB_DEPTH];

  // pointers carry one wrap bit above the slot index
  logic [`LSU_SB_PTR_W:0] wr_ptr;
  logic [`LSU_SB_PTR_W:0] rd_ptr;
  logic [`LSU_SB_PTR_W:0] sb_cnt;
  logic [`LSU_SB_PTR_W:0] enq_step;
  sb_ptr_t                wr_lo_idx;
  sb_ptr_t                wr_hi_idx;

  assign sb_cnt    = wr_ptr - rd_ptr;
  assign sb_free   = (`LSU_SB_PTR_W+1)'(`LSU_SB_DEPTH) - sb_cnt;
  assign enq_step  = {{(`LSU_SB_PTR_W-1){1'b0}}, enq_dual, ~enq_dual};  // 2 or 1
  assign wr_lo_idx = wr_ptr[`LSU_SB_PTR_W-1:0];
  assign wr_hi_idx = wr_lo_idx + 1'b1;

  // ******************************
  // pointers and storage
  // ******************************
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (enq_valid) wr_ptr <= wr_ptr + enq_step;
      if (head_pop)  rd_ptr <= rd_ptr + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (enq_valid) begin
      sb_addr[wr_lo_idx] <= r_lo_addr;
      sb_be[wr_lo_idx]   <= r_lo_be;
      sb_data[wr_lo_idx] <= r_lo_data;
      if (enq_dual) begin       // hi word takes the next slot
        sb_addr[wr_hi_idx] <= r_hi_addr;
        sb_be[wr_hi_idx]   <= r_hi_be;
        sb_data[wr_hi_idx] <= r_hi_data;
      end
    end
  end

  // head entry for the bus side
  assign head_valid = (sb_cnt != '0);
  assign head_ptr   = rd_ptr[`LSU_SB_PTR_W-1:0];
  assign head_addr  = sb_addr[head_ptr];
  assign head_be    = sb_be[head_ptr];
  assign head_data  = sb_data[head_ptr];

  // ******************************
  // byte lookup for m-stage loads
  // ******************************
  // walk oldest to youngest so the last match per byte wins
  always_comb begin
    sb_ptr_t idx;
    buf_hit_lo  = '0;
    buf_hit_hi  = '0;
    buf_data_lo = '0;
    buf_data_hi = '0;
    for (int k = 0; k < `LSU_SB_DEPTH; k++) begin
      idx = head_ptr + sb_ptr_t'(k);
      if (k < int'(sb_cnt)) begin
        for (int b = 0; b < 4; b++) begin
          if (sb_be[idx][b] && (sb_addr[idx] == m_lo_addr)) begin
            buf_hit_lo[b]        = 1'b1;
            buf_data_lo[8*b +: 8] = sb_data[idx][8*b +: 8];
          end
          if (sb_be[idx][b] && (sb_addr[idx] == m_hi_addr)) begin
            buf_hit_hi[b]        = 1'b1;
            buf_data_hi[8*b +: 8] = sb_data[idx][8*b +: 8];
          end
        end
      end
    end
  end

endmodule

/* src/lsu_pipe_stage.sv */
`timescale 1ns/10ps

module lsu_pipe_stage (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     m_valid,
  input  logic                     m_ready,
  input  logic                     m_load,
  input  logic                     m_store,
  input  lsu_pkg::access_size_e    m_size,
  input  logic [31:0]              m_addr,
  input  lsu_pkg::word_t           m_store_data,
  input  logic                     flush_r,
  output lsu_pkg::word_addr_t      m_lo_addr,
  output lsu_pkg::word_addr_t      m_hi_addr,
  output lsu_pkg::byte_en_t        m_lo_be,
  output lsu_pkg::byte_en_t        m_hi_be,
  output logic                     m_load_go,
  output lsu_pkg::word_addr_t      r_lo_addr,
  output lsu_pkg::word_addr_t      r_hi_addr,
  output lsu_pkg::byte_en_t        r_lo_be,
  output lsu_pkg::byte_en_t        r_hi_be,
  output lsu_pkg::word_t           r_lo_data,
  output lsu_pkg::word_t           r_hi_data,
  output logic                     r_fwd_valid,
  output logic                     enq_valid,
  output logic                     enq_dual
);
  import lsu_pkg::*;

  byte_en_t    size_mask;
  logic [7:0]  be_ext;    // enables over two words
  dword_t      data_ext;  // store data over two words
  logic        accept;
  logic        r_store;   // store sitting in r
  logic        r_dual;    // r store crosses a word

  // ******************************
  // m stage decode
  // ******************************
  always_comb begin
    unique case (m_size)
      size_byte: size_mask = 4'b0001;
      size_half: size_mask = 4'b0011;
      default:   size_mask = 4'b1111;
    endcase
  end

  assign be_ext   = {4'b0000, size_mask} << m_addr[1:0];
  assign data_ext = {32'h0, m_store_data} << {m_addr[1:0], 3'b000};

  assign m_lo_addr = m_addr[31:2];
  assign m_hi_addr = m_lo_addr + 1'b1;  // next word, used only when m_hi_be is set
  assign m_lo_be   = be_ext[3:0];
  assign m_hi_be   = be_ext[7:4];

  assign accept    = m_valid & m_ready;
  assign m_load_go = accept & m_load;

  // ******************************
  // r stage
  // ******************************
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      r_store <= 1'b0;
    end else begin
      r_store <= accept & m_store;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      r_lo_addr <= m_lo_addr;
      r_hi_addr <= m_hi_addr;
      r_lo_be   <= be_ext[3:0];
      r_hi_be   <= be_ext[7:4];
      r_lo_data <= data_ext[31:0];
      r_hi_data <= data_ext[63:32];
      r_dual    <= |be_ext[7:4];
    end
  end

  // a flushed store neither forwards nor commits
  assign r_fwd_valid = r_store & ~flush_r;
  assign enq_valid   = r_fwd_valid;
  assign enq_dual    = r_fwd_valid & r_dual;  // lo entry first, then hi

endmodule

/* src/lsu_pkg.sv */
`include "lsu_defs.svh"

package lsu_pkg;

  // ******************************
  // data path widths
  // ******************************
  typedef logic [31:0] word_t;       // one data word
  typedef logic [63:0] dword_t;      // AXI data beat
  typedef logic [29:0] word_addr_t;  // address above the byte offset
  typedef logic [3:0]  byte_en_t;    // byte enables of a word
  typedef logic [7:0]  strb_t;       // AXI write strobes

  typedef logic [`LSU_SB_PTR_W-1:0] sb_ptr_t;  // store buffer slot

  // access size as decoded by the core
  typedef enum logic [1:0] {
    size_byte = 2'b00,
    size_half = 2'b01,
    size_word = 2'b10
  } access_size_e;

  // write channel sequencing
  typedef enum logic [1:0] {
    wr_idle,
    wr_both,     // aw and w both outstanding
    wr_wait_aw,  // w done, aw pending
    wr_wait_w    // aw done, w pending
  } axi_wr_state_e;

endpackage

/* src/lsu_defs.svh */
`ifndef LSU_DEFS_SVH
`define LSU_DEFS_SVH

// ******************************
// store buffer geometry
// ******************************

// number of word entries, keep it a power of two
`define LSU_SB_DEPTH        8
`define LSU_SB_PTR_W        3

// ******************************
// AXI write side
// ******************************

// slot index doubles as awid
`define LSU_AXI_ID_W        `LSU_SB_PTR_W
`define LSU_AXI_SIZE_WORD   3'b010   // 4 bytes per beat
`define LSU_AXI_BURST_INCR  2'b01

`endif
